// File: src/dm_settings.svh
`ifndef DM_SETTINGS_SVH
`define DM_SETTINGS_SVH

// debug module configuration
`define DM_NR_HARTS      4
`define DM_DATA_COUNT    2
`define DM_PROGBUF_SIZE  4
`define DM_DBG_VERSION   2
`define DM_HARTSEL_W     20

`endif

// File: src/dmi_pkg.sv
`include "dm_settings.svh"

package dmi_pkg;

    typedef logic [6:0]  dmi_addr_t;
    typedef logic [31:0] dmi_word_t;

    typedef enum logic [1:0] {
        DTM_NOP   = 2'h0,
        DTM_READ  = 2'h1,
        DTM_WRITE = 2'h2
    } dtm_op_e;

    // the only response status this front end sends
    localparam logic [1:0] DTM_SUCCESS = 2'h0;

    typedef struct packed {
        dmi_addr_t addr;
        dtm_op_e   op;
        dmi_word_t data;
    } dmi_req_t;

    typedef struct packed {
        dmi_word_t  data;
        logic [1:0] resp;
    } dmi_resp_t;

endpackage

// File: src/dm_reg_pkg.sv
`include "dm_settings.svh"

package dm_reg_pkg;

    typedef enum logic [6:0] {
        Data0      = 7'h04,
        DMControl  = 7'h10,
        DMStatus   = 7'h11,
        AbstractCS = 7'h16,
        Command    = 7'h17,
        ProgBuf0   = 7'h20
    } dm_csr_e;

    typedef logic [`DM_NR_HARTS-1:0]         hart_vec_t;
    typedef logic [`DM_HARTSEL_W-1:0]        hartsel_t;
    typedef logic [$clog2(`DM_NR_HARTS)-1:0] hart_idx_t;

    // ------------------------------------------------------------
    // register layouts
    // ------------------------------------------------------------
    typedef struct packed {
        logic       haltreq;
        logic       resumereq;
        logic       hartreset;
        logic       ackhavereset;
        logic       zero1;
        logic       hasel;
        logic [9:0] hartsello;
        logic [9:0] hartselhi;
        logic [1:0] zero0;
        logic       setresethaltreq;
        logic       clrresethaltreq;
        logic       ndmreset;
        logic       dmactive;
    } dmcontrol_t;

    typedef struct packed {
        logic [8:0] zero1;
        logic       impebreak;
        logic [1:0] zero0;
        logic       allhavereset;
        logic       anyhavereset;
        logic       allresumeack;
        logic       anyresumeack;
        logic       allnonexistent;
        logic       anynonexistent;
        logic       allunavail;
        logic       anyunavail;
        logic       allrunning;
        logic       anyrunning;
        logic       allhalted;
        logic       anyhalted;
        logic       authenticated;
        logic       authbusy;
        logic       hasresethaltreq;
        logic       devtreeinvalid;
        logic [3:0] version;
    } dmstatus_t;

    typedef enum logic [2:0] {
        CmdErrNone = 3'h0,
        CmdErrBusy = 3'h1
    } cmderr_e;

    typedef struct packed {
        logic [2:0]  zero3;
        logic [4:0]  progbufsize;
        logic [10:0] zero2;
        logic        busy;
        logic        zero1;
        cmderr_e     cmderr;
        logic [3:0]  zero0;
        logic [3:0]  datacount;
    } abstractcs_t;

    typedef struct packed {
        logic [7:0]  cmdtype;
        logic [23:0] control;
    } command_t;

    // write strobes from the decoder
    // idx is the word offset in data or progbuf
    typedef struct packed {
        logic              dmcontrol;
        logic              abstractcs;
        logic              command;
        logic              data;
        logic              progbuf;
        logic [1:0]        idx;
        dmi_pkg::dmi_word_t wdata;
    } csr_wr_t;

endpackage

// File: src/dmi_resp_queue.sv
module dmi_resp_queue (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               push_i,
    input  dmi_pkg::dmi_word_t data_i,
    input  logic               pop_i,
    output logic               full_o,
    output logic               empty_o,
    output dmi_pkg::dmi_word_t data_o
);

    dmi_pkg::dmi_word_t mem_q [2];
    logic               wr_ptr_q;
    logic               rd_ptr_q;
    logic [1:0]         count_q;

    assign full_o  = (count_q == 2'd2);
    assign empty_o = (count_q == 2'd0);
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop_i) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // the decoder only pushes on accepted requests, the top only pops a valid entry
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        full_o |-> !push_i);
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        empty_o |-> !pop_i);

endmodule

// File: src/dm_csr_decode.sv
`include "dm_settings.svh"

module dm_csr_decode (
    input  logic                                     dmi_req_valid_i,
    input  dmi_pkg::dmi_req_t                        dmi_req_i,
    input  logic                                     ready_i,
    input  dm_reg_pkg::dmcontrol_t                   dmcontrol_i,
    input  dm_reg_pkg::dmstatus_t                    dmstatus_i,
    input  dm_reg_pkg::abstractcs_t                  abstractcs_i,
    input  dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   data_i,
    input  dmi_pkg::dmi_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_i,
    output logic                                     push_o,
    output dmi_pkg::dmi_word_t                       rdata_o,
    output dm_reg_pkg::csr_wr_t                      wr_o
);

    logic               accept;
    logic               in_data;
    logic               in_pb;
    dmi_pkg::dmi_addr_t data_off;
    dmi_pkg::dmi_addr_t pb_off;

    assign accept = dmi_req_valid_i & ready_i;
    assign push_o = accept;

    // offsets wrap below the base, so one compare covers the range
    assign data_off = dmi_req_i.addr - dm_reg_pkg::Data0;
    assign pb_off   = dmi_req_i.addr - dm_reg_pkg::ProgBuf0;
    assign in_data  = data_off < dmi_pkg::dmi_addr_t'(`DM_DATA_COUNT);
    assign in_pb    = pb_off < dmi_pkg::dmi_addr_t'(`DM_PROGBUF_SIZE);

    always_comb begin
        rdata_o    = '0;
        wr_o       = '0;
        wr_o.wdata = dmi_req_i.data;
        wr_o.idx   = in_data ? data_off[1:0] : pb_off[1:0];

        // read mux
        if (accept && dmi_req_i.op == dmi_pkg::DTM_READ) begin
            if (in_data) begin
                for (int i = 0; i < `DM_DATA_COUNT; i++) begin
                    if (int'(data_off) == i) begin
                        rdata_o = data_i[i];
                    end
                end
            end else if (in_pb) begin
                for (int i = 0; i < `DM_PROGBUF_SIZE; i++) begin
                    if (int'(pb_off) == i) begin
                        rdata_o = progbuf_i[i];
                    end
                end
            end else begin
                case (dmi_req_i.addr)
                    dm_reg_pkg::DMControl:  rdata_o = dmcontrol_i;
                    dm_reg_pkg::DMStatus:   rdata_o = dmstatus_i;
                    dm_reg_pkg::AbstractCS: rdata_o = abstractcs_i;
                    default:                rdata_o = '0;
                endcase
            end
        end

        // write strobes
        if (accept && dmi_req_i.op == dmi_pkg::DTM_WRITE) begin
            wr_o.data       = in_data;
            wr_o.progbuf    = in_pb;
            wr_o.dmcontrol  = (dmi_req_i.addr == dm_reg_pkg::DMControl);
            wr_o.abstractcs = (dmi_req_i.addr == dm_reg_pkg::AbstractCS);
            wr_o.command    = (dmi_req_i.addr == dm_reg_pkg::Command);
        end
    end

endmodule

// File: src/dm_ctrl_regs.sv
`include "dm_settings.svh"

module dm_ctrl_regs (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  dm_reg_pkg::csr_wr_t    wr_i,
    input  dm_reg_pkg::hart_vec_t  halted_i,
    input  dm_reg_pkg::hart_vec_t  unavailable_i,
    input  dm_reg_pkg::hart_vec_t  resumeack_i,
    output dm_reg_pkg::dmcontrol_t dmcontrol_o,
    output dm_reg_pkg::dmstatus_t  dmstatus_o,
    output logic                   dmactive_o,
    output logic                   ndmreset_o,
    output dm_reg_pkg::hartsel_t   hartsel_o,
    output dm_reg_pkg::hart_idx_t  hart_idx_o,
    output dm_reg_pkg::hart_vec_t  haltreq_o,
    output dm_reg_pkg::hart_vec_t  resumereq_o
);

    dm_reg_pkg::dmcontrol_t dmcontrol_d, dmcontrol_q;
    dm_reg_pkg::dmcontrol_t wr_ctrl;
    dm_reg_pkg::hart_vec_t  havereset_d, havereset_q;
    logic                   nonexist;

    assign wr_ctrl     = dm_reg_pkg::dmcontrol_t'(wr_i.wdata);
    assign dmcontrol_o = dmcontrol_q;
    assign dmactive_o  = dmcontrol_q.dmactive;
    assign ndmreset_o  = dmcontrol_q.ndmreset;
    assign hartsel_o   = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
    assign hart_idx_o  = hartsel_o[$bits(dm_reg_pkg::hart_idx_t)-1:0];
    assign nonexist    = hartsel_o >= dm_reg_pkg::hartsel_t'(`DM_NR_HARTS);

    // ------------------------------------------------------------
    // dmcontrol and havereset next state
    // ------------------------------------------------------------
    always_comb begin
        dmcontrol_d = dmcontrol_q;
        if (wr_i.dmcontrol) begin
            dmcontrol_d = wr_ctrl;
        end
        // no hart array, no hart reset, no reset-halt
        dmcontrol_d.hasel           = 1'b0;
        dmcontrol_d.hartreset       = 1'b0;
        dmcontrol_d.setresethaltreq = 1'b0;
        dmcontrol_d.clrresethaltreq = 1'b0;
        dmcontrol_d.zero1           = 1'b0;
        dmcontrol_d.zero0           = '0;
        dmcontrol_d.ackhavereset    = 1'b0;
        // inactive module only listens to dmactive
        if (!dmcontrol_q.dmactive) begin
            dmcontrol_d          = '0;
            dmcontrol_d.dmactive = wr_i.dmcontrol & wr_ctrl.dmactive;
        end

        havereset_d = havereset_q;
        if (wr_i.dmcontrol && dmcontrol_q.dmactive && wr_ctrl.ackhavereset && !nonexist) begin
            havereset_d[hart_idx_o] = 1'b0;
        end
        if (dmcontrol_q.ndmreset) begin
            havereset_d = '1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dmcontrol_q <= '0;
            havereset_q <= '1;
        end else begin
            dmcontrol_q <= dmcontrol_d;
            havereset_q <= havereset_d;
        end
    end

    // requests and status of the selected hart
    always_comb begin
        haltreq_o   = '0;
        resumereq_o = '0;
        dmstatus_o  = '0;
        dmstatus_o.version        = 4'(`DM_DBG_VERSION);
        dmstatus_o.authenticated  = 1'b1;
        dmstatus_o.allnonexistent = nonexist;
        dmstatus_o.anynonexistent = nonexist;
        if (!nonexist) begin
            haltreq_o[hart_idx_o]   = dmcontrol_q.haltreq;
            resumereq_o[hart_idx_o] = dmcontrol_q.resumereq;
            dmstatus_o.allhavereset = havereset_q[hart_idx_o];
            dmstatus_o.anyhavereset = havereset_q[hart_idx_o];
            dmstatus_o.allresumeack = resumeack_i[hart_idx_o];
            dmstatus_o.anyresumeack = resumeack_i[hart_idx_o];
            dmstatus_o.allunavail   = unavailable_i[hart_idx_o];
            dmstatus_o.anyunavail   = unavailable_i[hart_idx_o];
            dmstatus_o.allhalted    = halted_i[hart_idx_o];
            dmstatus_o.anyhalted    = halted_i[hart_idx_o];
            dmstatus_o.allrunning   = ~halted_i[hart_idx_o];
            dmstatus_o.anyrunning   = ~halted_i[hart_idx_o];
        end
    end

    a_haltreq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(haltreq_o));

endmodule

// File: src/dm_abstract_regs.sv
`include "dm_settings.svh"

module dm_abstract_regs (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  dm_reg_pkg::csr_wr_t                      wr_i,
    input  logic                                     dmactive_i,
    input  logic                                     cmdbusy_i,
    input  logic                                     cmderror_valid_i,
    input  dm_reg_pkg::cmderr_e                      cmderror_i,
    input  logic                                     data_valid_i,
    input  dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   data_i,
    output dm_reg_pkg::abstractcs_t                  abstractcs_o,
    output logic                                     cmd_valid_o,
    output dm_reg_pkg::command_t                     cmd_o,
    output dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   data_o,
    output dmi_pkg::dmi_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_o
);

    dm_reg_pkg::cmderr_e     cmderr_d, cmderr_q;
    dm_reg_pkg::command_t    command_d, command_q;
    dm_reg_pkg::abstractcs_t wr_cs;
    dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   data_d, data_q;
    dmi_pkg::dmi_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_d, progbuf_q;

    assign wr_cs     = dm_reg_pkg::abstractcs_t'(wr_i.wdata);
    assign cmd_o     = command_q;
    assign data_o    = data_q;
    assign progbuf_o = progbuf_q;

    always_comb begin
        abstractcs_o             = '0;
        abstractcs_o.datacount   = 4'(`DM_DATA_COUNT);
        abstractcs_o.progbufsize = 5'(`DM_PROGBUF_SIZE);
        abstractcs_o.busy        = cmdbusy_i;
        abstractcs_o.cmderr      = cmderr_q;
    end

    // ------------------------------------------------------------
    // command, cmderr and buffer updates
    // ------------------------------------------------------------
    always_comb begin
        cmderr_d    = cmderr_q;
        command_d   = command_q;
        data_d      = data_q;
        progbuf_d   = progbuf_q;
        cmd_valid_o = 1'b0;

        if (wr_i.command || wr_i.abstractcs) begin
            if (cmdbusy_i) begin
                // first access during a busy command flags it
                if (cmderr_q == dm_reg_pkg::CmdErrNone) begin
                    cmderr_d = dm_reg_pkg::CmdErrBusy;
                end
            end else if (wr_i.command) begin
                cmd_valid_o = 1'b1;
                command_d   = dm_reg_pkg::command_t'(wr_i.wdata);
            end else begin
                cmderr_d = dm_reg_pkg::cmderr_e'(cmderr_q & ~wr_cs.cmderr);
            end
        end

        if (!cmdbusy_i) begin
            for (int i = 0; i < `DM_DATA_COUNT; i++) begin
                if (wr_i.data && int'(wr_i.idx) == i) begin
                    data_d[i] = wr_i.wdata;
                end
            end
            for (int i = 0; i < `DM_PROGBUF_SIZE; i++) begin
                if (wr_i.progbuf && int'(wr_i.idx) == i) begin
                    progbuf_d[i] = wr_i.wdata;
                end
            end
        end

        // hart side wins over the bus
        if (cmderror_valid_i) begin
            cmderr_d = cmderror_i;
        end
        if (data_valid_i) begin
            data_d = data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmderr_q  <= dm_reg_pkg::CmdErrNone;
            command_q <= '0;
        end else if (!dmactive_i) begin
            cmderr_q  <= dm_reg_pkg::CmdErrNone;
            command_q <= '0;
        end else begin
            cmderr_q  <= cmderr_d;
            command_q <= command_d;
        end
    end

    // buffers clear while the module is inactive
    always_ff @(posedge clk_i) begin
        if (!dmactive_i) begin
            data_q    <= '0;
            progbuf_q <= '0;
        end else begin
            data_q    <= data_d;
            progbuf_q <= progbuf_d;
        end
    end

    a_no_cmd_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmdbusy_i |-> !cmd_valid_o);

endmodule

// File: src/dm_regs_top.sv
`include "dm_settings.svh"

module dm_regs_top (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    // debug bus
    input  logic                                     dmi_req_valid_i,
    output logic                                     dmi_req_ready_o,
    input  dmi_pkg::dmi_req_t                        dmi_req_i,
    output logic                                     dmi_resp_valid_o,
    input  logic                                     dmi_resp_ready_i,
    output dmi_pkg::dmi_resp_t                       dmi_resp_o,
    // hart control and status
    input  dm_reg_pkg::hart_vec_t                    halted_i,
    input  dm_reg_pkg::hart_vec_t                    unavailable_i,
    input  dm_reg_pkg::hart_vec_t                    resumeack_i,
    output logic                                     dmactive_o,
    output logic                                     ndmreset_o,
    output dm_reg_pkg::hartsel_t                     hartsel_o,
    output dm_reg_pkg::hart_idx_t                    hart_idx_o,
    output dm_reg_pkg::hart_vec_t                    haltreq_o,
    output dm_reg_pkg::hart_vec_t                    resumereq_o,
    // abstract commands
    input  logic                                     cmdbusy_i,
    input  logic                                     cmderror_valid_i,
    input  dm_reg_pkg::cmderr_e                      cmderror_i,
    input  logic                                     data_valid_i,
    input  dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   data_i,
    output logic                                     cmd_valid_o,
    output dm_reg_pkg::command_t                     cmd_o,
    output dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   data_o,
    output dmi_pkg::dmi_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_o
);

    logic                    q_full;
    logic                    q_empty;
    logic                    q_push;
    dmi_pkg::dmi_word_t      q_rdata;
    dm_reg_pkg::csr_wr_t     wr;
    dm_reg_pkg::dmcontrol_t  dmcontrol;
    dm_reg_pkg::dmstatus_t   dmstatus;
    dm_reg_pkg::abstractcs_t abstractcs;

    assign dmi_req_ready_o  = ~q_full;
    assign dmi_resp_valid_o = ~q_empty;
    assign dmi_resp_o.resp  = dmi_pkg::DTM_SUCCESS;

    dmi_resp_queue i_resp_queue (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (q_push),
        .data_i  (q_rdata),
        .pop_i   (dmi_resp_ready_i & ~q_empty),
        .full_o  (q_full),
        .empty_o (q_empty),
        .data_o  (dmi_resp_o.data)
    );

    dm_csr_decode i_decode (
        .dmi_req_valid_i (dmi_req_valid_i),
        .dmi_req_i       (dmi_req_i),
        .ready_i         (dmi_req_ready_o),
        .dmcontrol_i     (dmcontrol),
        .dmstatus_i      (dmstatus),
        .abstractcs_i    (abstractcs),
        .data_i          (data_o),
        .progbuf_i       (progbuf_o),
        .push_o          (q_push),
        .rdata_o         (q_rdata),
        .wr_o            (wr)
    );

    dm_ctrl_regs i_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .wr_i          (wr),
        .halted_i      (halted_i),
        .unavailable_i (unavailable_i),
        .resumeack_i   (resumeack_i),
        .dmcontrol_o   (dmcontrol),
        .dmstatus_o    (dmstatus),
        .dmactive_o    (dmactive_o),
        .ndmreset_o    (ndmreset_o),
        .hartsel_o     (hartsel_o),
        .hart_idx_o    (hart_idx_o),
        .haltreq_o     (haltreq_o),
        .resumereq_o   (resumereq_o)
    );

    dm_abstract_regs i_abstract (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .wr_i             (wr),
        .dmactive_i       (dmactive_o),
        .cmdbusy_i        (cmdbusy_i),
        .cmderror_valid_i (cmderror_valid_i),
        .cmderror_i       (cmderror_i),
        .data_valid_i     (data_valid_i),
        .data_i           (data_i),
        .abstractcs_o     (abstractcs),
        .cmd_valid_o      (cmd_valid_o),
        .cmd_o            (cmd_o),
        .data_o           (data_o),
        .progbuf_o        (progbuf_o)
    );

endmodule

// File: tb/tb_dm_regs.sv
`include "dm_settings.svh"

module tb_dm_regs;

    localparam int MAX_CYCLES = 2000;
    localparam logic [31:0] CTRL_MASK = 32'hC3FF_FFC3;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic dmi_req_valid_i, dmi_req_ready_o, dmi_resp_valid_o, dmi_resp_ready_i;
    dmi_pkg::dmi_req_t  dmi_req_i;
    dmi_pkg::dmi_resp_t dmi_resp_o;
    dm_reg_pkg::hart_vec_t halted_i, unavailable_i, resumeack_i, haltreq_o, resumereq_o;
    logic dmactive_o, ndmreset_o, cmdbusy_i, cmderror_valid_i, data_valid_i, cmd_valid_o;
    dm_reg_pkg::hartsel_t  hartsel_o;
    dm_reg_pkg::hart_idx_t hart_idx_o;
    dm_reg_pkg::cmderr_e   cmderror_i;
    dm_reg_pkg::command_t  cmd_o;
    dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   data_i, data_o;
    dmi_pkg::dmi_word_t [`DM_PROGBUF_SIZE-1:0] progbuf_o;

    // reference model state
    logic [31:0] m_ctrl, m_cmd, exp_head;
    logic [2:0]  m_cmderr;
    dm_reg_pkg::hart_vec_t m_haverst, exp_haltreq, exp_resumereq;
    dmi_pkg::dmi_word_t [`DM_DATA_COUNT-1:0]   m_data;
    dmi_pkg::dmi_word_t [`DM_PROGBUF_SIZE-1:0] m_pb;
    logic [31:0] exp_q [$];
    int exp_count, cycles, resp_errs, out_errs, misc_errs;
    logic acc;
    logic exp_cmd_valid;

    dm_regs_top DUT (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [19:0] sel_of(logic [31:0] c);
        return {c[15:6], c[25:16]};
    endfunction

    function automatic logic [31:0] read_model(logic [6:0] addr);
        dm_reg_pkg::dmstatus_t s;
        logic [19:0] sel;
        logic [1:0]  h;
        sel = sel_of(m_ctrl);
        h   = sel[1:0];
        s   = '0;
        s.version = 4'd2;
        s.authenticated  = 1'b1;
        s.allnonexistent = (sel >= 20'd4);
        s.anynonexistent = (sel >= 20'd4);
        if (sel < 20'd4) begin
            {s.allhavereset, s.anyhavereset} = {2{m_haverst[h]}};
            {s.allresumeack, s.anyresumeack} = {2{resumeack_i[h]}};
            {s.allunavail, s.anyunavail}     = {2{unavailable_i[h]}};
            {s.allhalted, s.anyhalted}       = {2{halted_i[h]}};
            {s.allrunning, s.anyrunning}     = {2{~halted_i[h]}};
        end
        if (addr == 7'h04 || addr == 7'h05) return m_data[addr - 7'h04];
        if (addr >= 7'h20 && addr <= 7'h23) return m_pb[addr - 7'h20];
        case (addr)
            7'h10:   return m_ctrl;
            7'h11:   return s;
            7'h16:   return {3'b0, 5'd4, 11'b0, cmdbusy_i, 1'b0, m_cmderr, 4'b0, 4'd2};
            default: return '0;
        endcase
    endfunction

    task automatic update_model(logic we, logic [6:0] addr, logic [31:0] data);
        logic active;
        logic [19:0] sel;
        active = m_ctrl[0];
        sel    = sel_of(m_ctrl);
        if (we && addr == 7'h10 && active && data[28] && sel < 20'd4) m_haverst[sel[1:0]] = 1'b0;
        if (m_ctrl[1]) m_haverst = '1;
        if (!active) begin
            m_cmderr = '0;
            m_cmd    = '0;
            m_data   = '0;
            m_pb     = '0;
        end else begin
            if (we && (addr == 7'h16 || addr == 7'h17)) begin
                if (cmdbusy_i) begin
                    if (m_cmderr == 3'd0) m_cmderr = 3'd1;
                end else if (addr == 7'h17) begin
                    m_cmd = data;
                end else begin
                    m_cmderr = m_cmderr & ~data[10:8];
                end
            end
            if (we && !cmdbusy_i && (addr == 7'h04 || addr == 7'h05)) m_data[addr - 7'h04] = data;
            if (we && !cmdbusy_i && addr >= 7'h20 && addr <= 7'h23) m_pb[addr - 7'h20] = data;
            if (cmderror_valid_i) m_cmderr = cmderror_i;
            if (data_valid_i) m_data = data_i;
        end
        // inactive module only takes dmactive
        if (!active) m_ctrl = (we && addr == 7'h10) ? {31'b0, data[0]} : '0;
        else if (we && addr == 7'h10) m_ctrl = data & CTRL_MASK;
    endtask

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            {m_ctrl, m_cmd, m_cmderr, m_data, m_pb} = '0;
            m_haverst = '1;
            exp_q.delete();
        end else begin
            acc = dmi_req_valid_i && dmi_req_ready_o;
            if (dmi_resp_valid_o && dmi_resp_ready_i && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (acc) exp_q.push_back(dmi_req_i.op == dmi_pkg::DTM_READ ?
                                     read_model(dmi_req_i.addr) : 32'h0);
            update_model(acc && dmi_req_i.op == dmi_pkg::DTM_WRITE, dmi_req_i.addr,
                         dmi_req_i.data);
        end
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
    end

    always_comb begin
        exp_haltreq   = '0;
        exp_resumereq = '0;
        if (sel_of(m_ctrl) < 20'd4) begin
            exp_haltreq[m_ctrl[17:16]]   = m_ctrl[31];
            exp_resumereq[m_ctrl[17:16]] = m_ctrl[30];
        end
    end

    // pulse only for an accepted command write while not busy
    assign exp_cmd_valid = dmi_req_valid_i && dmi_req_ready_o && !cmdbusy_i &&
                           dmi_req_i.op == dmi_pkg::DTM_WRITE && dmi_req_i.addr == 7'h17;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    a_resp_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmi_resp_valid_o && dmi_resp_ready_i |->
            dmi_resp_o.data == exp_head && dmi_resp_o.resp == dmi_pkg::DTM_SUCCESS)
        else begin
            resp_errs++;
            $display("ERROR %0t dmi_resp_o data/resp expected %h/%h got %h/%h", $time,
                     $sampled(exp_head), dmi_pkg::DTM_SUCCESS,
                     $sampled(dmi_resp_o.data), $sampled(dmi_resp_o.resp));
        end
    a_resp_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmi_resp_valid_o == (exp_count != 0))
        else begin
            out_errs++;
            $display("ERROR %0t dmi_resp_valid_o expected %0b got %0b", $time,
                     $sampled(exp_count != 0), $sampled(dmi_resp_valid_o));
        end
    a_req_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmi_req_ready_o == (exp_count < 2))
        else begin
            out_errs++;
            $display("ERROR %0t dmi_req_ready_o expected %0b got %0b", $time,
                     $sampled(exp_count < 2), $sampled(dmi_req_ready_o));
        end
    a_haltreq: assert property (@(posedge clk_i) disable iff (!rst_ni)
        haltreq_o == exp_haltreq && resumereq_o == exp_resumereq)
        else begin
            out_errs++;
            $display("ERROR %0t haltreq_o/resumereq_o expected %h/%h got %h/%h", $time,
                     $sampled(exp_haltreq), $sampled(exp_resumereq),
                     $sampled(haltreq_o), $sampled(resumereq_o));
        end
    a_ctrl_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmactive_o == m_ctrl[0] && ndmreset_o == m_ctrl[1])
        else begin
            out_errs++;
            $display("ERROR %0t dmactive_o/ndmreset_o expected %0b/%0b got %0b/%0b", $time,
                     $sampled(m_ctrl[0]), $sampled(m_ctrl[1]),
                     $sampled(dmactive_o), $sampled(ndmreset_o));
        end
    a_hartsel: assert property (@(posedge clk_i) disable iff (!rst_ni)
        hartsel_o == sel_of(m_ctrl) && hart_idx_o == m_ctrl[17:16])
        else begin
            out_errs++;
            $display("ERROR %0t hartsel_o/hart_idx_o expected %h/%h got %h/%h", $time,
                     sel_of($sampled(m_ctrl)), $sampled(m_ctrl[17:16]),
                     $sampled(hartsel_o), $sampled(hart_idx_o));
        end
    a_cmd_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmd_valid_o == exp_cmd_valid)
        else begin
            out_errs++;
            $display("ERROR %0t cmd_valid_o expected %0b got %0b", $time,
                     $sampled(exp_cmd_valid), $sampled(cmd_valid_o));
        end
    a_cmd: assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_o == m_cmd)
        else begin
            out_errs++;
            $display("ERROR %0t cmd_o expected %h got %h", $time, $sampled(m_cmd),
                     $sampled(cmd_o));
        end
    a_buffers: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_o == m_data && progbuf_o == m_pb)
        else begin
            out_errs++;
            $display("ERROR %0t data_o/progbuf_o expected %h/%h got %h/%h", $time,
                     $sampled(m_data), $sampled(m_pb),
                     $sampled(data_o), $sampled(progbuf_o));
        end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic wait_accept();
        logic ok;
        do begin
            @(posedge clk_i);
            ok = dmi_req_ready_o;
        end while (!ok);
        #1 dmi_req_valid_i = 1'b0;
    endtask

    task automatic send(dmi_pkg::dtm_op_e op, logic [6:0] addr, logic [31:0] data);
        dmi_req_valid_i = 1'b1;
        dmi_req_i       = '{addr: addr, op: op, data: data};
        wait_accept();
    endtask

    task automatic wr(logic [6:0] addr, logic [31:0] data);
        send(dmi_pkg::DTM_WRITE, addr, data);
    endtask

    task automatic rd(logic [6:0] addr);
        send(dmi_pkg::DTM_READ, addr, 32'h0);
    endtask

    // returns once the response queue is empty
    task automatic drain_responses();
        while (dmi_resp_valid_o) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, responses still pending: %0d",
                     cycles, exp_count);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(75));
        {rst_ni, dmi_req_valid_i, dmi_req_i, cmdbusy_i, cmderror_valid_i, data_valid_i} = '0;
        {halted_i, unavailable_i, resumeack_i, data_i} = '0;
        cmderror_i = dm_reg_pkg::CmdErrNone;
        dmi_resp_ready_i = 1'b1;
        repeat (3) @(posedge clk_i);
        #1 rst_ni = 1'b1;

        // inactive module ignores haltreq
        wr(7'h10, 32'h8000_0000);
        rd(7'h10);
        wr(7'h10, 32'h1);
        rd(7'h11);
        for (int h = 0; h < 6; h++) begin
            halted_i      = 4'($urandom);
            unavailable_i = 4'($urandom);
            resumeack_i   = 4'($urandom);
            wr(7'h10, 32'h8000_0001 | (h << 16));
            rd(7'h11);
            wr(7'h10, 32'h4000_0001 | (h << 16));
            rd(7'h11);
            wr(7'h10, 32'h1000_0001 | (h << 16));
            rd(7'h11);
        end
        // ndmreset brings havereset back
        wr(7'h10, 32'h3);
        wr(7'h10, 32'h1);
        rd(7'h11);

        wr(7'h17, $urandom);
        cmdbusy_i = 1'b1;
        wr(7'h17, $urandom);
        rd(7'h16);
        wr(7'h04, $urandom);
        wr(7'h21, $urandom);
        cmdbusy_i = 1'b0;
        rd(7'h04);
        wr(7'h16, 32'h700);
        rd(7'h16);
        cmderror_valid_i = 1'b1;
        cmderror_i       = dm_reg_pkg::cmderr_e'(3'd3);
        @(posedge clk_i);
        #1 cmderror_valid_i = 1'b0;
        rd(7'h16);

        for (int a = 0; a < 2; a++) wr(7'(7'h04 + a), $urandom);
        for (int a = 0; a < 4; a++) wr(7'(7'h20 + a), $urandom);
        for (int a = 0; a < 2; a++) rd(7'(7'h04 + a));
        for (int a = 0; a < 4; a++) rd(7'(7'h20 + a));
        data_i       = {$urandom, $urandom};
        data_valid_i = 1'b1;
        @(posedge clk_i);
        #1 data_valid_i = 1'b0;
        rd(7'h04);
        rd(7'h05);

        // third request stalls under back-pressure until a pop
        drain_responses();
        dmi_resp_ready_i = 1'b0;
        rd(7'h05);
        rd(7'h10);
        dmi_req_valid_i = 1'b1;
        dmi_req_i       = '{addr: 7'h16, op: dmi_pkg::DTM_READ, data: 32'h0};
        repeat (4) @(posedge clk_i);
        #1 dmi_resp_ready_i = 1'b1;
        wait_accept();
        drain_responses();

        if (exp_count != 0) begin
            misc_errs++;
            $display("responses were lost, %0d still expected", exp_count);
        end
        $display("errors: response %0d, outputs %0d, other %0d", resp_errs, out_errs, misc_errs);
        if (resp_errs + out_errs + misc_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+src
src/dmi_pkg.sv
src/dm_reg_pkg.sv
src/dmi_resp_queue.sv
src/dm_csr_decode.sv
src/dm_ctrl_regs.sv
src/dm_abstract_regs.sv
src/dm_regs_top.sv
tb/tb_dm_regs.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dm_regs
RTL_TOP   ?= dm_regs_top
FLIST     ?= list.f
BUILD     ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(shell cat $(FLIST) | grep -v '^+') $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
